/* verilog/core_pkg.sv */
package core_pkg;

    // memory-mapped uart words, compared against address bits 9..0 only
    localparam logic [9:0] UART_IN_ADDR        = 10'd0;
    localparam logic [9:0] UART_IN_VALID_ADDR  = 10'd4;
    localparam logic [9:0] UART_OUT_VALID_ADDR = 10'd8;
    localparam logic [9:0] UART_OUT_ADDR       = 10'd12;

    // data ram geometry, word index is address bits 11..2
    localparam int DMEM_WORDS = 1024;
    localparam int DMEM_AW    = 10;

    // uart fifo geometry, depth must stay a power of two
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = 2;

    // decoded instruction as handed over by execute
    typedef struct packed {
        logic [5:0] rd;
        logic       regwrite;
        logic       memread;
        logic       memwrite;
        logic       memtoreg;
        logic       imemwrite;
    } inst_t;

    // what a data address selects
    typedef enum logic [2:0] {
        region_ram,
        region_uart_in,
        region_uart_in_valid,
        region_uart_out_valid,
        region_uart_out
    } mem_region_t;

    // stage -> uart port block
    typedef struct packed {
        logic       rd_en;
        logic       wr_en;
        logic [7:0] tx_byte;
    } uart_req_t;

    // uart port block -> stage, all levels
    typedef struct packed {
        logic [7:0] rx_byte;
        logic       rx_empty;
        logic       tx_full;
    } uart_stat_t;

    // register file write-back
    typedef struct packed {
        logic [5:0]  rd;
        logic        regwrite;
        logic [31:0] wdata;
    } wb_t;

    // instruction memory write request
    typedef struct packed {
        logic        en;
        logic [31:0] addr;
        logic [31:0] data;
    } imem_wr_t;

endpackage

/* verilog/data_ram.sv */
module data_ram (
    input  logic                       clk,
    input  logic                       en,
    input  logic                       we,
    input  logic [core_pkg::DMEM_AW-1:0] addr,
    input  logic [31:0]                wdata,
    output logic [31:0]                rdata
);

    // word array, no reset so it maps onto block ram
    logic [31:0] mem [core_pkg::DMEM_WORDS];

    // write port
    always_ff @(posedge clk) begin
        if (en && we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, write-first
    // rdata only moves when en is high so a stalled load keeps its word
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                rdata <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* verilog/byte_fifo.sv */
module byte_fifo (
    input  logic       clk,
    input  logic       rstn,
    input  logic       push,
    input  logic [7:0] din,
    input  logic       pop,
    output logic [7:0] dout,
    output logic       empty,
    output logic       full
);

    // circular buffer storage
    logic [7:0] buffer [core_pkg::FIFO_DEPTH];

    // pointers wrap by themselves since depth is 2**aw
    logic [core_pkg::FIFO_AW-1:0] wr_ptr;
    logic [core_pkg::FIFO_AW-1:0] rd_ptr;

    // occupancy, one bit wider than the pointers to reach depth
    logic [core_pkg::FIFO_AW:0] count;

    logic do_push;
    logic do_pop;

    // push dropped when full, pop ignored when empty
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (core_pkg::FIFO_AW + 1)'(core_pkg::FIFO_DEPTH));

    // head of queue, shown combinationally
    assign dout = buffer[rd_ptr];

    // payload store
    always_ff @(posedge clk) begin
        if (do_push) begin
            buffer[wr_ptr] <= din;
        end
    end

    // pointer and count update
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // occupancy bound holds across any push/pop sequence
    a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
        count <= (core_pkg::FIFO_AW + 1)'(core_pkg::FIFO_DEPTH));

    a_flags_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(full && empty));

endmodule

/* verilog/uart_port_regs.sv */
module uart_port_regs (
    input  logic                 clk,
    input  logic                 rstn,
    input  core_pkg::uart_req_t  req,
    output core_pkg::uart_stat_t stat,
    input  logic                 rx_push,
    input  logic [7:0]           rx_byte_in,
    input  logic                 tx_pop,
    output logic                 tx_valid,
    output logic [7:0]           tx_byte_out
);

    // receive side
    logic [7:0] rx_head;
    logic       rx_empty;

    // transmit side
    logic       tx_empty;
    logic       tx_full;

    // receive fifo
    // filled from the outside port, drained by loads of UART_IN_ADDR
    byte_fifo rx_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .push  (rx_push),
        .din   (rx_byte_in),
        .pop   (req.rd_en),
        .dout  (rx_head),
        .empty (rx_empty),
        // overflow just drops the byte, nothing to report upstream
        .full  ()
    );

    // transmit fifo
    // filled by stores to UART_OUT_ADDR, drained by the serializer side
    byte_fifo tx_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .push  (req.wr_en),
        .din   (req.tx_byte),
        .pop   (tx_pop),
        .dout  (tx_byte_out),
        .empty (tx_empty),
        .full  (tx_full)
    );

    // status back to the stage
    // head reads as zero when nothing is queued
    always_comb begin
        stat.rx_byte  = rx_empty ? 8'h00 : rx_head;
        stat.rx_empty = rx_empty;
        stat.tx_full  = tx_full;
    end

    // far end sees a byte whenever tx fifo holds one
    assign tx_valid = !tx_empty;

    // the stage only ever strobes one port per registered instruction,
    // a load and a store cannot share a slot
    a_single_strobe: assert property (@(posedge clk) disable iff (!rstn)
        !(req.rd_en && req.wr_en));

endmodule

/* verilog/mem_stage.sv */
module mem_stage (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         enable,
    input  core_pkg::inst_t              inst,
    input  logic [31:0]                  aluresult,
    input  logic [31:0]                  result,
    input  logic [31:0]                  rdata1,
    output logic                         ram_en,
    output logic                         ram_we,
    output logic [core_pkg::DMEM_AW-1:0] ram_addr,
    output logic [31:0]                  ram_wdata,
    input  logic [31:0]                  ram_rdata,
    output core_pkg::uart_req_t          uart_req,
    input  core_pkg::uart_stat_t         uart_stat,
    output core_pkg::wb_t                wb,
    output core_pkg::imem_wr_t           imem_wr
);

    // execute -> memory pipeline register
    core_pkg::inst_t inst_q;
    logic [31:0]     aluresult_q;
    logic [31:0]     result_q;
    logic [31:0]     rdata1_q;

    // decoded regions, live for the ram access and registered for the rest
    core_pkg::mem_region_t region_live;
    core_pkg::mem_region_t region_q;

    // load data after the uart/ram select
    logic [31:0] load_data;

    // only bits 9..0 matter, anything not a uart word is ram
    function automatic core_pkg::mem_region_t decode_region(input logic [31:0] addr);
        core_pkg::mem_region_t region;
        unique case (addr[9:0])
            core_pkg::UART_IN_ADDR:        region = core_pkg::region_uart_in;
            core_pkg::UART_IN_VALID_ADDR:  region = core_pkg::region_uart_in_valid;
            core_pkg::UART_OUT_VALID_ADDR: region = core_pkg::region_uart_out_valid;
            core_pkg::UART_OUT_ADDR:       region = core_pkg::region_uart_out;
            default:                       region = core_pkg::region_ram;
        endcase
        return region;
    endfunction

    // control part, cleared to a bubble
    always_ff @(posedge clk) begin
        if (!rstn) begin
            inst_q <= '0;
        end else if (enable) begin
            inst_q <= inst;
        end
    end

    // payload part
    always_ff @(posedge clk) begin
        if (enable) begin
            aluresult_q <= aluresult;
            result_q    <= result;
            rdata1_q    <= rdata1;
        end
    end

    assign region_live = decode_region(aluresult);
    assign region_q    = decode_region(aluresult_q);

    // ram is driven from the un-registered inputs
    // so its read data lines up with the registered instruction
    assign ram_en    = enable;
    assign ram_we    = enable && inst.memwrite && (region_live != core_pkg::region_uart_out);
    assign ram_addr  = aluresult[core_pkg::DMEM_AW+1:2];
    assign ram_wdata = rdata1;

    // uart strobes
    // enable gates them so a stalled access strobes exactly once,
    // on the edge where it leaves the register
    always_comb begin
        uart_req.rd_en   = enable && inst_q.memread
                           && (region_q == core_pkg::region_uart_in);
        uart_req.wr_en   = enable && inst_q.memwrite
                           && (region_q == core_pkg::region_uart_out);
        uart_req.tx_byte = rdata1_q[7:0];
    end

    // load data select
    always_comb begin
        unique case (region_q)
            core_pkg::region_uart_in:
                load_data = {24'b0, uart_stat.rx_byte};
            core_pkg::region_uart_in_valid:
                load_data = {31'b0, !uart_stat.rx_empty};
            core_pkg::region_uart_out_valid:
                load_data = {31'b0, !uart_stat.tx_full};
            // ram word, also for a load of the tx data word
            default:
                load_data = ram_rdata;
        endcase
    end

    // write-back
    always_comb begin
        wb.rd       = inst_q.rd;
        wb.regwrite = inst_q.regwrite;
        wb.wdata    = inst_q.memtoreg ? load_data : result_q;
    end

    // imem write, address from alu and data from rs
    always_comb begin
        imem_wr.en   = inst_q.imemwrite;
        imem_wr.addr = aluresult_q;
        imem_wr.data = rdata1_q;
    end

    // decode never hands over a load that is also a store
    a_no_load_store: assert property (@(posedge clk) disable iff (!rstn)
        !(inst_q.memread && inst_q.memwrite));

endmodule

/* verilog/mem_subsys_top.sv */
module mem_subsys_top (
    input  logic               clk,
    input  logic               rstn,
    input  logic               enable,
    input  core_pkg::inst_t    inst,
    input  logic [31:0]        aluresult,
    input  logic [31:0]        result,
    input  logic [31:0]        rdata1,
    output core_pkg::wb_t      wb,
    output core_pkg::imem_wr_t imem_wr,
    input  logic               rx_push,
    input  logic [7:0]         rx_byte_in,
    input  logic               tx_pop,
    output logic               tx_valid,
    output logic [7:0]         tx_byte_out
);

    // stage <-> data ram
    logic                         ram_en;
    logic                         ram_we;
    logic [core_pkg::DMEM_AW-1:0] ram_addr;
    logic [31:0]                  ram_wdata;
    logic [31:0]                  ram_rdata;

    // stage <-> uart port block
    core_pkg::uart_req_t  uart_req;
    core_pkg::uart_stat_t uart_stat;

    mem_stage u_mem_stage (
        .clk       (clk),
        .rstn      (rstn),
        .enable    (enable),
        .inst      (inst),
        .aluresult (aluresult),
        .result    (result),
        .rdata1    (rdata1),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .uart_req  (uart_req),
        .uart_stat (uart_stat),
        .wb        (wb),
        .imem_wr   (imem_wr)
    );

    data_ram u_dmem (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    // uart fifos, serializer ends brought out as plain ports
    uart_port_regs u_uart (
        .clk         (clk),
        .rstn        (rstn),
        .req         (uart_req),
        .stat        (uart_stat),
        .rx_push     (rx_push),
        .rx_byte_in  (rx_byte_in),
        .tx_pop      (tx_pop),
        .tx_valid    (tx_valid),
        .tx_byte_out (tx_byte_out)
    );

endmodule

/* testbench/tb_mem_subsys.sv */
module tb_mem_subsys;

    // bound on ops and cycles per op, stall included
    localparam int N_OPS         = 96;
    localparam int MAX_OP_CYCLES = 4;
    localparam int WATCHDOG_TIME = (N_OPS * MAX_OP_CYCLES + 16) * 20;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic clk;
    logic rstn;
    logic enable;
    core_pkg::inst_t    inst;
    logic [31:0]        aluresult;
    logic [31:0]        result;
    logic [31:0]        rdata1;
    core_pkg::wb_t      wb;
    core_pkg::imem_wr_t imem_wr;
    logic               rx_push;
    logic [7:0]         rx_byte_in;
    logic               tx_pop;
    logic               tx_valid;
    logic [7:0]         tx_byte_out;

    // reference model state
    logic [31:0]           ram_m [core_pkg::DMEM_WORDS];
    logic [7:0]            rx_q [$];
    logic [7:0]            tx_q [$];
    core_pkg::inst_t       m_inst;
    core_pkg::mem_region_t m_region;
    logic [31:0]           m_alu;
    logic [31:0]           m_res;
    logic [31:0]           m_rd1;
    logic [31:0]           m_load;

    // expected outputs for the cycle after each edge
    core_pkg::wb_t      exp_wb;
    core_pkg::imem_wr_t exp_imem;
    logic               exp_tx_valid;
    logic [7:0]         exp_tx_byte;

    logic [31:0] lfsr_state = 32'd21;

    mem_subsys_top uut (
        .clk         (clk),
        .rstn        (rstn),
        .enable      (enable),
        .inst        (inst),
        .aluresult   (aluresult),
        .result      (result),
        .rdata1      (rdata1),
        .wb          (wb),
        .imem_wr     (imem_wr),
        .rx_push     (rx_push),
        .rx_byte_in  (rx_byte_in),
        .tx_pop      (tx_pop),
        .tx_valid    (tx_valid),
        .tx_byte_out (tx_byte_out)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < n; i++) begin
            bit_out    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (bit_out) begin
                lfsr_state = lfsr_state ^ LFSR_TAPS;
            end
            value = {value[30:0], bit_out};
        end
        return value;
    endfunction

    // mostly back to back, sometimes a two cycle gap
    function automatic int rand_gap();
        return (rand_bits(2) == 32'd3) ? 2 : 0;
    endfunction

    function automatic core_pkg::inst_t make_inst(input logic [5:0] rd, input logic rw,
            input logic mr, input logic mw, input logic m2r, input logic iw);
        core_pkg::inst_t i;
        i.rd        = rd;
        i.regwrite  = rw;
        i.memread   = mr;
        i.memwrite  = mw;
        i.memtoreg  = m2r;
        i.imemwrite = iw;
        return i;
    endfunction

    // ram address for a word index, random upper and byte bits
    function automatic logic [31:0] ram_address(input logic [9:0] idx);
        logic [3:0] up;
        logic [1:0] lo;
        up = 4'(rand_bits(4));
        lo = 2'(rand_bits(2));
        return {16'h0, up, idx, lo};
    endfunction

    // uart word, junk above bit 9 must not matter
    function automatic logic [31:0] uart_address(input logic [9:0] offset);
        logic [21:0] up;
        up = 22'(rand_bits(22));
        return {up, offset};
    endfunction

    // expected region of an address, straight from the decode rule
    function automatic core_pkg::mem_region_t region_of(input logic [31:0] a);
        if (a[9:0] == core_pkg::UART_IN_ADDR) return core_pkg::region_uart_in;
        if (a[9:0] == core_pkg::UART_IN_VALID_ADDR) return core_pkg::region_uart_in_valid;
        if (a[9:0] == core_pkg::UART_OUT_VALID_ADDR) return core_pkg::region_uart_out_valid;
        if (a[9:0] == core_pkg::UART_OUT_ADDR) return core_pkg::region_uart_out;
        return core_pkg::region_ram;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] expected,
            input logic [127:0] actual);
        $display("Error at time %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // edge, then inputs move 2 units later
    task automatic next_cycle();
        @(posedge clk);
        #2;
        rx_push = 1'b0;
        tx_pop  = 1'b0;
    endtask

    // one instruction, captured at the next edge, then a stall
    task automatic send(input core_pkg::inst_t i, input logic [31:0] alu,
            input logic [31:0] res, input logic [31:0] rd1, input int stall);
        enable    = 1'b1;
        inst      = i;
        aluresult = alu;
        result    = res;
        rdata1    = rd1;
        next_cycle();
        repeat (stall) begin
            enable = 1'b0;
            // junk store while stalled, must not reach the ram
            inst      = make_inst(6'(rand_bits(6)), 1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
            aluresult = ram_address(10'(8 + rand_bits(3)));
            rdata1    = rand_bits(32);
            result    = rand_bits(32);
            next_cycle();
        end
    endtask

    task automatic load_op(input logic [31:0] addr, input int stall);
        send(make_inst(6'(rand_bits(6)), 1'b1, 1'b1, 1'b0, 1'b1, 1'b0), addr,
             rand_bits(32), rand_bits(32), stall);
    endtask

    task automatic store_op(input logic [31:0] addr, input logic [31:0] data, input int stall);
        send(make_inst(6'(rand_bits(6)), 1'b0, 1'b0, 1'b1, 1'b0, 1'b0), addr,
             rand_bits(32), data, stall);
    endtask

    task automatic push_rx(input logic [7:0] b);
        rx_push    = 1'b1;
        rx_byte_in = b;
        send('0, 32'h0, 32'h0, 32'h0, 0);
    endtask

    task automatic pop_tx();
        tx_pop = 1'b1;
        send('0, 32'h0, 32'h0, 32'h0, 0);
    endtask

    // model follows the capture and strobe rules at each edge
    always @(posedge clk) begin : ref_model
        logic        do_rx_pop;
        logic        do_rx_push;
        logic        do_tx_push;
        logic        do_tx_pop;
        logic [31:0] wdata_m;
        if (!rstn) begin
            rx_q.delete();
            tx_q.delete();
            m_inst   = '0;
            m_region = core_pkg::region_ram;
            m_alu    = '0;
            m_res    = '0;
            m_rd1    = '0;
            m_load   = '0;
        end else begin
            // strobes come from the held instruction, flags from pre-edge fill
            do_rx_pop  = enable && m_inst.memread && (m_region == core_pkg::region_uart_in)
                         && (rx_q.size() != 0);
            do_tx_push = enable && m_inst.memwrite && (m_region == core_pkg::region_uart_out)
                         && (tx_q.size() < core_pkg::FIFO_DEPTH);
            do_rx_push = rx_push && (rx_q.size() < core_pkg::FIFO_DEPTH);
            do_tx_pop  = tx_pop && (tx_q.size() != 0);
            if (do_rx_pop) void'(rx_q.pop_front());
            if (do_rx_push) rx_q.push_back(rx_byte_in);
            if (do_tx_pop) void'(tx_q.pop_front());
            if (do_tx_push) tx_q.push_back(m_rd1[7:0]);
            if (enable) begin
                // tx word store skips the ram, read sees the new word
                if (inst.memwrite && region_of(aluresult) != core_pkg::region_uart_out) begin
                    ram_m[aluresult[11:2]] = rdata1;
                end
                m_load   = ram_m[aluresult[11:2]];
                m_inst   = inst;
                m_region = region_of(aluresult);
                m_alu    = aluresult;
                m_res    = result;
                m_rd1    = rdata1;
            end
        end
        if (!m_inst.memtoreg) begin
            wdata_m = m_res;
        end else if (m_region == core_pkg::region_uart_in) begin
            wdata_m = (rx_q.size() != 0) ? {24'h0, rx_q[0]} : 32'h0;
        end else if (m_region == core_pkg::region_uart_in_valid) begin
            wdata_m = {31'h0, rx_q.size() != 0};
        end else if (m_region == core_pkg::region_uart_out_valid) begin
            wdata_m = {31'h0, tx_q.size() < core_pkg::FIFO_DEPTH};
        end else begin
            wdata_m = m_load;
        end
        exp_wb.rd       <= m_inst.rd;
        exp_wb.regwrite <= m_inst.regwrite;
        exp_wb.wdata    <= wdata_m;
        exp_imem.en     <= m_inst.imemwrite;
        exp_imem.addr   <= m_alu;
        exp_imem.data   <= m_rd1;
        exp_tx_valid    <= (tx_q.size() != 0);
        exp_tx_byte     <= (tx_q.size() != 0) ? tx_q[0] : 8'h00;
    end

    a_wb_match: assert property (@(posedge clk) disable iff (!rstn) wb === exp_wb)
        else report_mismatch("wb", 128'($sampled(exp_wb)), 128'($sampled(wb)));

    a_imem_match: assert property (@(posedge clk) disable iff (!rstn) imem_wr === exp_imem)
        else report_mismatch("imem_wr", 128'($sampled(exp_imem)), 128'($sampled(imem_wr)));

    a_tx_valid_match: assert property (@(posedge clk) disable iff (!rstn)
        tx_valid === exp_tx_valid)
        else report_mismatch("tx_valid", 128'($sampled(exp_tx_valid)), 128'($sampled(tx_valid)));

    // byte only defined while something is queued
    a_tx_byte_match: assert property (@(posedge clk) disable iff (!rstn)
        !exp_tx_valid || tx_byte_out === exp_tx_byte)
        else report_mismatch("tx_byte_out", 128'($sampled(exp_tx_byte)),
                             128'($sampled(tx_byte_out)));

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("watchdog expired, tests did not complete in time");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    initial begin : stimulus
        // zeros captured during reset keep the payload defined
        rstn       = 1'b0;
        enable     = 1'b1;
        inst       = '0;
        aluresult  = '0;
        result     = '0;
        rdata1     = '0;
        rx_push    = 1'b0;
        rx_byte_in = '0;
        tx_pop     = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;

        // ram, seed every word used below, index 3 included
        store_op(32'h0000_000D, rand_bits(32), 0);
        for (int k = 8; k < 16; k++) store_op(ram_address(10'(k)), rand_bits(32), 0);
        for (int k = 0; k < 24; k++) begin
            if (rand_bits(1) != 0) begin
                store_op(ram_address(10'(8 + rand_bits(3))), rand_bits(32), rand_gap());
            end else begin
                load_op(ram_address(10'(8 + rand_bits(3))), rand_gap());
            end
        end
        // tx word store, then ram word 3 through another address
        store_op(32'h0000_000C, rand_bits(32), 0);
        load_op(32'h0000_100D, 0);
        pop_tx();

        // pass-through of result and imem write
        for (int k = 0; k < 8; k++) begin
            send(make_inst(6'(rand_bits(6)), 1'(rand_bits(1)), 1'b0, 1'b0, 1'b0,
                 1'(rand_bits(1))), rand_bits(32), rand_bits(32), rand_bits(32), rand_gap());
        end

        // receive in order, then empty reads
        for (int k = 0; k < 3; k++) push_rx(8'(rand_bits(8)));
        load_op(uart_address(core_pkg::UART_IN_VALID_ADDR), 0);
        for (int k = 0; k < 3; k++) load_op(uart_address(core_pkg::UART_IN_ADDR), 0);
        load_op(uart_address(core_pkg::UART_IN_VALID_ADDR), 0);
        load_op(uart_address(core_pkg::UART_IN_ADDR), 0);
        load_op(uart_address(core_pkg::UART_IN_VALID_ADDR), 0);
        // fifth push lands on a full fifo
        for (int k = 0; k < 5; k++) push_rx(8'(rand_bits(8)));
        for (int k = 0; k < 5; k++) load_op(uart_address(core_pkg::UART_IN_ADDR), 0);

        // transmit in order, then fill up
        for (int k = 0; k < 2; k++) store_op(uart_address(core_pkg::UART_OUT_ADDR), rand_bits(32), 0);
        pop_tx();
        pop_tx();
        load_op(uart_address(core_pkg::UART_OUT_VALID_ADDR), 0);
        for (int k = 0; k < 4; k++) store_op(uart_address(core_pkg::UART_OUT_ADDR), rand_bits(32), 0);
        load_op(uart_address(core_pkg::UART_OUT_VALID_ADDR), 0);
        store_op(uart_address(core_pkg::UART_OUT_ADDR), rand_bits(32), 0);
        for (int k = 0; k < 5; k++) pop_tx();

        // uart accesses held across a stall strobe once
        push_rx(8'(rand_bits(8)));
        push_rx(8'(rand_bits(8)));
        load_op(uart_address(core_pkg::UART_IN_ADDR), 3);
        load_op(uart_address(core_pkg::UART_IN_VALID_ADDR), 0);
        load_op(uart_address(core_pkg::UART_IN_ADDR), 0);
        load_op(uart_address(core_pkg::UART_IN_VALID_ADDR), 0);
        store_op(uart_address(core_pkg::UART_OUT_ADDR), rand_bits(32), 3);
        pop_tx();
        pop_tx();

        enable = 1'b0;
        next_cycle();
        next_cycle();
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* flist.f */
verilog/core_pkg.sv
verilog/data_ram.sv
verilog/byte_fifo.sv
verilog/uart_port_regs.sv
verilog/mem_stage.sv
verilog/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

/* run.sh */
#!/bin/sh
# build with verilator and run, exit status is the simulation result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module tb_mem_subsys -o sim_tb \
    && ./obj_dir/sim_tb \
    || exit 1
